//--- all.f
+incdir+logic
logic/max_norm_pkg.sv
logic/pass_sequencer.sv
logic/lane_max_tree.sv
logic/lane_subtract.sv
logic/diff_sum_tree.sv
logic/max_norm_top.sv
test/max_norm_tb.sv

//--- Bender.yml
package:
  name: max_norm

export_include_dirs:
  - logic

sources:
  - logic/max_norm_pkg.sv
  - logic/pass_sequencer.sv
  - logic/lane_max_tree.sv
  - logic/lane_subtract.sv
  - logic/diff_sum_tree.sv
  - logic/max_norm_top.sv
  - target: test
    files:
      - test/max_norm_tb.sv

//--- test/max_norm_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "max_norm_defines.svh"

module max_norm_tb import max_norm_pkg::*; ();

  localparam int RUN_TIMEOUT = 20000;
  localparam int IDLE_WINDOW = 2000;

  logic  clk;
  logic  reset;
  logic  start;
  addr_t start_addr;
  addr_t end_addr;
  addr_t addr;
  data_t rd_data0;
  data_t rd_data1;
  data_t rd_data2;
  data_t rd_data3;
  logic  out_valid;
  diff_t out_data0;
  diff_t out_data1;
  diff_t out_data2;
  diff_t out_data3;
  logic  credit_return;
  data_t max_value;
  sum_t  sum;
  logic  done;

  logic [63:0] mem [512];
  logic [31:0] lfsr;
  int          delay_tab [64];
  logic [67:0] beats [$];
  int          errors;
  int          tests;
  int          tests_failed;
  int          done_count;
  data_t       done_max;
  sum_t        done_sum;
  int          unreturned;
  int          owed;
  int          wait_cnt;
  int          delay_idx;

  max_norm_top dut0 (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .start_addr    (start_addr),
    .end_addr      (end_addr),
    .addr          (addr),
    .rd_data0      (rd_data0),
    .rd_data1      (rd_data1),
    .rd_data2      (rd_data2),
    .rd_data3      (rd_data3),
    .out_valid     (out_valid),
    .out_data0     (out_data0),
    .out_data1     (out_data1),
    .out_data2     (out_data2),
    .out_data3     (out_data3),
    .credit_return (credit_return),
    .max_value     (max_value),
    .sum           (sum),
    .done          (done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // memory answers one cycle after the address
  always @(posedge clk) begin
    rd_data0 <= mem[addr][15:0];
    rd_data1 <= mem[addr][31:16];
    rd_data2 <= mem[addr][47:32];
    rd_data3 <= mem[addr][63:48];
  end

  // consumer takes every beat and returns one credit per beat after a random gap
  always @(posedge clk) begin
    if (reset) begin
      credit_return <= 1'b0;
      unreturned = 0;
      owed = 0;
      wait_cnt = 0;
      delay_idx = 0;
    end else begin
      // the dut counts the pulse it sees on this edge
      if (credit_return) unreturned--;
      if (out_valid) begin
        unreturned++;
        owed++;
        beats.push_back({out_data3, out_data2, out_data1, out_data0});
      end
      if (unreturned > `CREDITS) begin
        $display("credit overrun: %0d beats outstanding, limit is %0d", unreturned, `CREDITS);
        errors++;
      end
      if (done) begin
        done_count++;
        done_max = max_value;
        done_sum = sum;
      end
      if (wait_cnt != 0) begin
        wait_cnt--;
        credit_return <= 1'b0;
      end else if (owed != 0) begin
        credit_return <= 1'b1;
        owed--;
        wait_cnt = delay_tab[delay_idx];
        delay_idx = (delay_idx + 1) % 64;
      end else begin
        credit_return <= 1'b0;
      end
    end
  end

  task automatic report_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: FAILED", name);
    end
  endtask

  task automatic run_range(input addr_t s, input addr_t e, input string name);
    int    n;
    int    errs_before;
    int    mx;
    int    total;
    int    exp_d;
    data_t v;
    diff_t got;
    errs_before = errors;
    beats.delete();
    done_count = 0;
    @(posedge clk);
    start      <= 1'b1;
    start_addr <= s;
    end_addr   <= e;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (done_count == 0 && n < RUN_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (done_count == 0) begin
      $display("%s: no done within %0d cycles", name, RUN_TIMEOUT);
      errors++;
    end else begin
      // watch for a second done pulse
      for (n = 0; n < 20; n++) @(posedge clk);
      if (done_count != 1) begin
        $display("%s: %0d done pulses for one run", name, done_count);
        errors++;
      end
      // model computes the range maximum, then each lane minus it and their total
      mx = data_t'(mem[s][15:0]);
      for (int a = s; a < e; a++) begin
        for (int k = 0; k < 4; k++) begin
          v = mem[a][16*k +: 16];
          if (v > mx) mx = v;
        end
      end
      total = 0;
      for (int a = s; a < e; a++) begin
        for (int k = 0; k < 4; k++) begin
          v = mem[a][16*k +: 16];
          total += v - mx;
        end
      end
      if (done_max !== data_t'(mx)) begin
        $display("** Error %s: max_value got %h expected %h", name, done_max, data_t'(mx));
        errors++;
      end
      if (done_sum !== sum_t'(total)) begin
        $display("** Error %s: sum got %h expected %h", name, done_sum, sum_t'(total));
        errors++;
      end
      if (beats.size() != e - s) begin
        $display("%s: %0d beats arrived for %0d words", name, beats.size(), e - s);
        errors++;
      end
      for (int i = 0; i < beats.size() && i < e - s; i++) begin
        for (int k = 0; k < 4; k++) begin
          v = mem[s + i][16*k +: 16];
          exp_d = v - mx;
          got = beats[i][17*k +: 17];
          if (got !== diff_t'(exp_d)) begin
            $display("** Error %s: out_data%0d beat %0d got %h expected %h",
                     name, k, i, got, diff_t'(exp_d));
            errors++;
          end
        end
      end
    end
    report_test(name, errs_before);
  endtask

  task automatic ignored_start(input addr_t s, input addr_t e, input string name);
    int n;
    int errs_before;
    errs_before = errors;
    beats.delete();
    done_count = 0;
    @(posedge clk);
    start      <= 1'b1;
    start_addr <= s;
    end_addr   <= e;
    @(posedge clk);
    start <= 1'b0;
    n = 0;
    while (beats.size() == 0 && done_count == 0 && n < IDLE_WINDOW) begin
      @(posedge clk);
      n++;
    end
    if (beats.size() != 0) begin
      $display("%s: a beat came out after an empty range start", name);
      errors++;
    end
    if (done_count != 0) begin
      $display("%s: done pulsed after an empty range start", name);
      errors++;
    end
    report_test(name, errs_before);
  endtask

  initial begin
    int s;
    int len;
    int errs_before;
    string name;
    reset         = 1'b1;
    start         = 1'b0;
    start_addr    = '0;
    end_addr      = '0;
    credit_return = 1'b0;
    rd_data0      = '0;
    rd_data1      = '0;
    rd_data2      = '0;
    rd_data3      = '0;
    errors        = 0;
    tests         = 0;
    tests_failed  = 0;
    done_count    = 0;
    lfsr          = 32'h98c9;
    for (int a = 0; a < 512; a++) begin
      mem[a][31:0]  = rand_bits(32);
      mem[a][63:32] = rand_bits(32);
    end
    for (int i = 0; i < 64; i++) begin
      delay_tab[i] = rand_bits(3);
    end

    repeat (10) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);

    // idle outputs after reset
    errs_before = errors;
    if (out_valid !== 1'b0) begin
      $display("** Error reset: out_valid got %h expected %h", out_valid, 1'b0);
      errors++;
    end
    if (done !== 1'b0) begin
      $display("** Error reset: done got %h expected %h", done, 1'b0);
      errors++;
    end
    if (addr !== addr_t'(0)) begin
      $display("** Error reset: addr got %h expected %h", addr, addr_t'(0));
      errors++;
    end
    report_test("reset state", errs_before);

    s = rand_bits(9) % 400;
    len = rand_bits(6) + 1;
    run_range(addr_t'(s), addr_t'(s + len), "random range");
    run_range(addr_t'(100), addr_t'(300), "slow credit return");

    for (int r = 0; r < 4; r++) begin
      s = rand_bits(9) % 400;
      len = rand_bits(6) + 1;
      name = $sformatf("back to back %0d", r);
      run_range(addr_t'(s), addr_t'(s + len), name);
    end
    run_range(addr_t'(37), addr_t'(38), "one word range");
    run_range(addr_t'(480), addr_t'(511), "range at top address");

    ignored_start(addr_t'(200), addr_t'(200), "empty range");
    ignored_start(addr_t'(300), addr_t'(120), "reversed range");
    run_range(addr_t'(10), addr_t'(42), "run after ignored starts");

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/max_norm_top.sv
`timescale 1ns/1ps
`default_nettype none

module max_norm_top import max_norm_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  start,
  input  wire addr_t start_addr,
  input  wire addr_t end_addr,
  output addr_t      addr,
  input  wire data_t rd_data0,
  input  wire data_t rd_data1,
  input  wire data_t rd_data2,
  input  wire data_t rd_data3,
  output logic       out_valid,
  output diff_t      out_data0,
  output diff_t      out_data1,
  output diff_t      out_data2,
  output diff_t      out_data3,
  input  wire logic  credit_return,
  output data_t      max_value,
  output sum_t       sum,
  output logic       done
);

  logic max_in_valid;
  logic max_in_last;
  logic sub_in_valid;
  logic sub_in_last;
  logic max_done;
  logic out_last;

  pass_sequencer seq0 (
    .clk           (clk),
    .reset         (reset),
    .start         (start),
    .start_addr    (start_addr),
    .end_addr      (end_addr),
    .max_done      (max_done),
    .credit_return (credit_return),
    .addr          (addr),
    .max_in_valid  (max_in_valid),
    .max_in_last   (max_in_last),
    .sub_in_valid  (sub_in_valid),
    .sub_in_last   (sub_in_last)
  );

  // pass 1 datapath
  lane_max_tree max0 (
    .clk       (clk),
    .reset     (reset),
    .lane0     (rd_data0),
    .lane1     (rd_data1),
    .lane2     (rd_data2),
    .lane3     (rd_data3),
    .in_valid  (max_in_valid),
    .in_last   (max_in_last),
    .max_value (max_value),
    .max_done  (max_done)
  );

  // pass 2 datapath
  lane_subtract sub0 (
    .clk       (clk),
    .reset     (reset),
    .lane0     (rd_data0),
    .lane1     (rd_data1),
    .lane2     (rd_data2),
    .lane3     (rd_data3),
    .max_value (max_value),
    .in_valid  (sub_in_valid),
    .in_last   (sub_in_last),
    .out_valid (out_valid),
    .out_last  (out_last),
    .out_data0 (out_data0),
    .out_data1 (out_data1),
    .out_data2 (out_data2),
    .out_data3 (out_data3)
  );

  diff_sum_tree acc0 (
    .clk      (clk),
    .reset    (reset),
    .diff0    (out_data0),
    .diff1    (out_data1),
    .diff2    (out_data2),
    .diff3    (out_data3),
    .in_valid (out_valid),
    .in_last  (out_last),
    .sum      (sum),
    .done     (done)
  );

endmodule

`default_nettype wire

//--- logic/diff_sum_tree.sv
`timescale 1ns/1ps
`default_nettype none

module diff_sum_tree import max_norm_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire diff_t diff0,
  input  wire diff_t diff1,
  input  wire diff_t diff2,
  input  wire diff_t diff3,
  input  wire logic  in_valid,
  input  wire logic  in_last,
  output sum_t       sum,
  output logic       done
);

  sum_t sum01;
  sum_t sum23;
  sum_t pair_total;
  logic s1_valid;
  logic s1_last;
  logic s2_valid;
  logic s2_last;
  logic first;

  // level one and level two of the adder tree
  always_ff @(posedge clk) begin
    sum01      <= sum_t'(diff0) + sum_t'(diff1);
    sum23      <= sum_t'(diff2) + sum_t'(diff3);
    pair_total <= sum01 + sum23;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      s2_valid <= 1'b0;
      s2_last  <= 1'b0;
      first    <= 1'b1;
      done     <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s1_last  <= in_valid && in_last;
      s2_valid <= s1_valid;
      s2_last  <= s1_valid && s1_last;
      done     <= s2_valid && s2_last;
      if (s2_valid) begin
        first <= s2_last;
      end
    end
  end

  // accumulator restarts on the first beat of a run
  always_ff @(posedge clk) begin
    if (s2_valid) begin
      if (first) begin
        sum <= pair_total;
      end else begin
        sum <= sum + pair_total;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/lane_subtract.sv
`timescale 1ns/1ps
`default_nettype none

module lane_subtract import max_norm_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire data_t lane0,
  input  wire data_t lane1,
  input  wire data_t lane2,
  input  wire data_t lane3,
  input  wire data_t max_value,
  input  wire logic  in_valid,
  input  wire logic  in_last,
  output logic       out_valid,
  output logic       out_last,
  output diff_t      out_data0,
  output diff_t      out_data1,
  output diff_t      out_data2,
  output diff_t      out_data3
);

  diff_t max_ext;

  // one extra bit so the difference cannot wrap
  assign max_ext = diff_t'(max_value);

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data0 <= diff_t'(lane0) - max_ext;
      out_data1 <= diff_t'(lane1) - max_ext;
      out_data2 <= diff_t'(lane2) - max_ext;
      out_data3 <= diff_t'(lane3) - max_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= in_valid;
      out_last  <= in_valid && in_last;
    end
  end

endmodule

`default_nettype wire

//--- logic/lane_max_tree.sv
`timescale 1ns/1ps
`default_nettype none

module lane_max_tree import max_norm_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire data_t lane0,
  input  wire data_t lane1,
  input  wire data_t lane2,
  input  wire data_t lane3,
  input  wire logic  in_valid,
  input  wire logic  in_last,
  output data_t      max_value,
  output logic       max_done
);

  data_t max01;
  data_t max23;
  data_t word_max;
  logic  s1_valid;
  logic  s1_last;
  logic  first;

  assign word_max = (max01 > max23) ? max01 : max23;

  // first stage compares the lanes in pairs
  always_ff @(posedge clk) begin
    max01 <= (lane0 > lane1) ? lane0 : lane1;
    max23 <= (lane2 > lane3) ? lane2 : lane3;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s1_last  <= 1'b0;
      first    <= 1'b1;
      max_done <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s1_last  <= in_valid && in_last;
      max_done <= s1_valid && s1_last;
      // the word after a last word opens the next run
      if (s1_valid) begin
        first <= s1_last;
      end
    end
  end

  // second stage keeps the running maximum
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      if (first || (word_max > max_value)) begin
        max_value <= word_max;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/pass_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "max_norm_defines.svh"

module pass_sequencer import max_norm_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  start,
  input  wire addr_t start_addr,
  input  wire addr_t end_addr,
  input  wire logic  max_done,
  input  wire logic  credit_return,
  output addr_t      addr,
  output logic       max_in_valid,
  output logic       max_in_last,
  output logic       sub_in_valid,
  output logic       sub_in_last
);

  pass_state_e state;
  addr_t       first_addr;
  addr_t       last_addr;
  credit_t     credits;
  logic        start_ok;
  logic        at_last;
  logic        max_issue;
  logic        sub_issue;

  // empty ranges and starts during a run are dropped
  assign start_ok = start && (state == IDLE) && (end_addr > start_addr);
  assign at_last  = (addr == last_addr);

  // pass 1 reads every cycle, pass 2 only with a credit in hand
  assign max_issue = (state == MAX_PASS);
  assign sub_issue = (state == SUB_PASS) && (credits != '0);

  // range is held for both passes
  always_ff @(posedge clk) begin
    if (start_ok) begin
      first_addr <= start_addr;
      last_addr  <= end_addr - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= IDLE;
      addr         <= '0;
      credits      <= credit_t'(`CREDITS);
      max_in_valid <= 1'b0;
      max_in_last  <= 1'b0;
      sub_in_valid <= 1'b0;
      sub_in_last  <= 1'b0;
    end else begin
      // read data shows up one cycle after its address
      max_in_valid <= max_issue;
      max_in_last  <= max_issue && at_last;
      sub_in_valid <= sub_issue;
      sub_in_last  <= sub_issue && at_last;

      // a take and a return in the same cycle cancel out
      credits <= credits - credit_t'(sub_issue) + credit_t'(credit_return);

      case (state)
        IDLE: begin
          if (start_ok) begin
            addr  <= start_addr;
            state <= MAX_PASS;
          end
        end
        MAX_PASS: begin
          if (at_last) begin
            state <= MAX_DRAIN;
          end else begin
            addr <= addr + 1'b1;
          end
        end
        MAX_DRAIN: begin
          // wait for the compare pipeline to settle the maximum
          if (max_done) begin
            addr  <= first_addr;
            state <= SUB_PASS;
          end
        end
        SUB_PASS: begin
          // addr holds while out of credits
          if (sub_issue) begin
            if (at_last) begin
              state <= SUB_DRAIN;
            end else begin
              addr <= addr + 1'b1;
            end
          end
        end
        SUB_DRAIN: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/max_norm_pkg.sv
`default_nettype none

package max_norm_pkg;

  `include "max_norm_defines.svh"

  typedef logic signed [`DATA_WIDTH-1:0] data_t;

  // lane minus maximum is never positive
  typedef logic signed [`DATA_WIDTH:0] diff_t;

  typedef logic signed [`SUM_WIDTH-1:0] sum_t;
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`CREDIT_WIDTH-1:0] credit_t;

  typedef enum logic [2:0] {
    IDLE,
    MAX_PASS,
    MAX_DRAIN,
    SUB_PASS,
    SUB_DRAIN
  } pass_state_e;

endpackage

`default_nettype wire

//--- logic/max_norm_defines.svh
`ifndef MAX_NORM_DEFINES_SVH
`define MAX_NORM_DEFINES_SVH

// lane value width
`define DATA_WIDTH 16
// lanes per memory word
`define LANES 4
// memory address width
`define ADDR_WIDTH 9

// credits held after reset and the counter that keeps them
`define CREDITS 4
`define CREDIT_WIDTH 3

// 512 words of four 17-bit differences
`define SUM_WIDTH 28

`endif
